// File: Makefile
TOP := tb_mc_link_to_sdr_north

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module mc_link_to_sdr_north

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/mc_link_pkg.sv
package mc_link_pkg;

  // Tile coordinates
  localparam int X_CORD_W = 4;
  localparam int Y_CORD_W = 3;

  // Forward packet fields
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 32;
  localparam int OPCODE_W = 2;

  // Return packet type field
  localparam int RTYPE_W = 2;

  // Forward: addr, data, opcode, src and dst coordinates
  localparam int FWD_W = ADDR_W + DATA_W + OPCODE_W
                       + 2 * (X_CORD_W + Y_CORD_W);

  // Reverse: data, type, dst coordinates
  localparam int REV_W = DATA_W + RTYPE_W + X_CORD_W + Y_CORD_W;

  // Receive FIFO sizing, also the sender's initial credit
  localparam int LG_FIFO_DEPTH = 3;
  localparam int FIFO_DEPTH    = 1 << LG_FIFO_DEPTH;
  localparam int FIFO_PTR_W    = LG_FIFO_DEPTH + 1; // Extra wrap bit

  // One token is worth this many credits
  localparam int LG_DECIM          = 1;
  localparam int CREDITS_PER_TOKEN = 1 << LG_DECIM;

  // Counter must hold the full depth
  localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

  localparam int SYNC_STAGES = 2;

endpackage

// File: design/mc_link_to_sdr_north.sv
`timescale 1ns/1ps

module mc_link_to_sdr_north
  import mc_link_pkg::*;
  (input  logic                core_clk_i
  ,input  logic                arst_n_i

  ,input  logic                core_reset_i
  ,output logic [1:0]          core_reset_o
  ,input  logic [X_CORD_W-1:0] core_global_x_i
  ,input  logic [Y_CORD_W-1:0] core_global_y_i
  ,output logic [X_CORD_W-1:0] core_global_x_o
  ,output logic [Y_CORD_W-1:0] core_global_y_o

  ,input  logic                async_uplink_reset_i
  ,input  logic                async_downlink_reset_i
  ,input  logic                async_downstream_reset_i
  ,input  logic                async_token_reset_i
  ,output logic                async_uplink_reset_o
  ,output logic                async_downlink_reset_o
  ,output logic                async_downstream_reset_o
  ,output logic                async_token_reset_o

  ,input  logic                async_fwd_link_i_disable_i
  ,input  logic                async_fwd_link_o_disable_i
  ,input  logic                async_rev_link_i_disable_i
  ,input  logic                async_rev_link_o_disable_i

  ,input  logic                core_fwd_v_i
  ,input  logic [FWD_W-1:0]    core_fwd_data_i
  ,output logic                core_fwd_ready_o
  ,output logic                core_fwd_v_o
  ,output logic [FWD_W-1:0]    core_fwd_data_o
  ,input  logic                core_fwd_ready_i

  ,input  logic                core_rev_v_i
  ,input  logic [REV_W-1:0]    core_rev_data_i
  ,output logic                core_rev_ready_o
  ,output logic                core_rev_v_o
  ,output logic [REV_W-1:0]    core_rev_data_o
  ,input  logic                core_rev_ready_i

  ,output logic                io_fwd_link_v_o
  ,output logic [FWD_W-1:0]    io_fwd_link_data_o
  ,input  logic                io_fwd_link_token_i
  ,input  logic                io_fwd_link_v_i
  ,input  logic [FWD_W-1:0]    io_fwd_link_data_i
  ,output logic                io_fwd_link_token_o

  ,output logic                io_rev_link_v_o
  ,output logic [REV_W-1:0]    io_rev_link_data_o
  ,input  logic                io_rev_link_token_i
  ,input  logic                io_rev_link_v_i
  ,input  logic [REV_W-1:0]    io_rev_link_data_i
  ,output logic                io_rev_link_token_o
  );

  logic uplink_reset_sync;
  logic downstream_reset_sync;
  logic up_reset;
  logic down_reset;

  // Resets leave the tile untouched for the next one in the chain
  assign async_uplink_reset_o     = async_uplink_reset_i;
  assign async_downlink_reset_o   = async_downlink_reset_i;
  assign async_downstream_reset_o = async_downstream_reset_i;
  assign async_token_reset_o      = async_token_reset_i;

  assign up_reset   = uplink_reset_sync | async_token_reset_i;
  assign down_reset = downstream_reset_sync | async_downlink_reset_i;

  mc_tile_regs u_tile_regs
    (.core_clk_i               (core_clk_i)
    ,.arst_n_i                 (arst_n_i)
    ,.core_reset_i             (core_reset_i)
    ,.core_global_x_i          (core_global_x_i)
    ,.core_global_y_i          (core_global_y_i)
    ,.async_uplink_reset_i     (async_uplink_reset_i)
    ,.async_downstream_reset_i (async_downstream_reset_i)
    ,.core_reset_o             (core_reset_o)
    ,.core_global_x_o          (core_global_x_o)
    ,.core_global_y_o          (core_global_y_o)
    ,.uplink_reset_sync_o      (uplink_reset_sync)
    ,.downstream_reset_sync_o  (downstream_reset_sync)
    );

  sdr_link #(.width_p(FWD_W)) u_fwd_sdr
    (.core_clk_i    (core_clk_i)
    ,.arst_n_i      (arst_n_i)
    ,.up_reset_i    (up_reset)
    ,.down_reset_i  (down_reset)
    ,.out_disable_i (async_fwd_link_o_disable_i)
    ,.in_disable_i  (async_fwd_link_i_disable_i)
    ,.core_v_i      (core_fwd_v_i)
    ,.core_data_i   (core_fwd_data_i)
    ,.core_ready_o  (core_fwd_ready_o)
    ,.core_v_o      (core_fwd_v_o)
    ,.core_data_o   (core_fwd_data_o)
    ,.core_ready_i  (core_fwd_ready_i)
    ,.link_v_o      (io_fwd_link_v_o)
    ,.link_data_o   (io_fwd_link_data_o)
    ,.link_token_i  (io_fwd_link_token_i)
    ,.link_v_i      (io_fwd_link_v_i)
    ,.link_data_i   (io_fwd_link_data_i)
    ,.link_token_o  (io_fwd_link_token_o)
    );

  sdr_link #(.width_p(REV_W)) u_rev_sdr
    (.core_clk_i    (core_clk_i)
    ,.arst_n_i      (arst_n_i)
    ,.up_reset_i    (up_reset)
    ,.down_reset_i  (down_reset)
    ,.out_disable_i (async_rev_link_o_disable_i)
    ,.in_disable_i  (async_rev_link_i_disable_i)
    ,.core_v_i      (core_rev_v_i)
    ,.core_data_i   (core_rev_data_i)
    ,.core_ready_o  (core_rev_ready_o)
    ,.core_v_o      (core_rev_v_o)
    ,.core_data_o   (core_rev_data_o)
    ,.core_ready_i  (core_rev_ready_i)
    ,.link_v_o      (io_rev_link_v_o)
    ,.link_data_o   (io_rev_link_data_o)
    ,.link_token_i  (io_rev_link_token_i)
    ,.link_v_i      (io_rev_link_v_i)
    ,.link_data_i   (io_rev_link_data_i)
    ,.link_token_o  (io_rev_link_token_o)
    );

endmodule

// File: design/mc_tile_regs.sv
`timescale 1ns/1ps

module mc_tile_regs
  import mc_link_pkg::*;
  (input  logic                core_clk_i
  ,input  logic                arst_n_i
  ,input  logic                core_reset_i
  ,input  logic [X_CORD_W-1:0] core_global_x_i
  ,input  logic [Y_CORD_W-1:0] core_global_y_i
  ,input  logic                async_uplink_reset_i
  ,input  logic                async_downstream_reset_i
  ,output logic [1:0]          core_reset_o
  ,output logic [X_CORD_W-1:0] core_global_x_o
  ,output logic [Y_CORD_W-1:0] core_global_y_o
  ,output logic                uplink_reset_sync_o
  ,output logic                downstream_reset_sync_o
  );

  logic                core_reset_r;
  logic [X_CORD_W-1:0] global_x_r;
  logic [Y_CORD_W-1:0] global_y_r;
  // Bit 0 uplink, bit 1 downstream
  logic [SYNC_STAGES-1:0][1:0] sync_r;

  // Reset and coordinates cross the whole die, so retime them per tile
  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      core_reset_r <= 1'b1; // Held in reset until first sample
      global_x_r   <= '0;
      global_y_r   <= '0;
    end else begin
      core_reset_r <= core_reset_i;
      global_x_r   <= core_global_x_i;
      global_y_r   <= core_global_y_i;
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_r <= '0;
    end else begin
      sync_r <= {sync_r[SYNC_STAGES-2:0], {async_downstream_reset_i, async_uplink_reset_i}};
    end
  end

  assign core_reset_o            = {2{core_reset_r}};
  assign core_global_x_o         = global_x_r;
  assign core_global_y_o         = global_y_r;
  assign uplink_reset_sync_o     = sync_r[SYNC_STAGES-1][0];
  assign downstream_reset_sync_o = sync_r[SYNC_STAGES-1][1];

endmodule

// File: sdr_link/sdr_link.sv
`timescale 1ns/1ps

module sdr_link
  #(parameter int width_p = 32)
  (input  logic               core_clk_i
  ,input  logic               arst_n_i
  ,input  logic               up_reset_i
  ,input  logic               down_reset_i
  ,input  logic               out_disable_i
  ,input  logic               in_disable_i

  ,input  logic               core_v_i
  ,input  logic [width_p-1:0] core_data_i
  ,output logic               core_ready_o
  ,output logic               core_v_o
  ,output logic [width_p-1:0] core_data_o
  ,input  logic               core_ready_i

  ,output logic               link_v_o
  ,output logic [width_p-1:0] link_data_o
  ,input  logic               link_token_i
  ,input  logic               link_v_i
  ,input  logic [width_p-1:0] link_data_i
  ,output logic               link_token_o
  );

  logic tx_reset;
  logic rx_reset;

  // A disabled half-link simply sits in reset
  assign tx_reset = up_reset_i | out_disable_i;
  assign rx_reset = down_reset_i | in_disable_i;

  sdr_link_up #(.width_p(width_p)) u_up
    (.core_clk_i   (core_clk_i)
    ,.arst_n_i     (arst_n_i)
    ,.reset_i      (tx_reset)
    ,.core_v_i     (core_v_i)
    ,.core_data_i  (core_data_i)
    ,.core_ready_o (core_ready_o)
    ,.link_v_o     (link_v_o)
    ,.link_data_o  (link_data_o)
    ,.link_token_i (link_token_i)
    );

  sdr_link_down #(.width_p(width_p)) u_down
    (.core_clk_i   (core_clk_i)
    ,.arst_n_i     (arst_n_i)
    ,.reset_i      (rx_reset)
    ,.link_v_i     (link_v_i)
    ,.link_data_i  (link_data_i)
    ,.link_token_o (link_token_o)
    ,.core_v_o     (core_v_o)
    ,.core_data_o  (core_data_o)
    ,.core_ready_i (core_ready_i)
    );

  // Far sender must stay quiet while this receiver is held
  a_no_rx_in_reset : assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    rx_reset |-> !link_v_i
  );

endmodule

// File: sdr_link/sdr_link_down.sv
`timescale 1ns/1ps

module sdr_link_down
  import mc_link_pkg::*;
  #(parameter int width_p = 32)
  (input  logic               core_clk_i
  ,input  logic               arst_n_i
  ,input  logic               reset_i

  ,input  logic               link_v_i
  ,input  logic [width_p-1:0] link_data_i
  ,output logic               link_token_o

  ,output logic               core_v_o
  ,output logic [width_p-1:0] core_data_o
  ,input  logic               core_ready_i
  );

  logic [width_p-1:0]    mem_r [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wptr_r;
  logic [FIFO_PTR_W-1:0] rptr_r;
  logic [LG_DECIM-1:0]   deq_cnt_r;
  logic                  token_r;
  logic                  empty;
  logic                  full;
  logic                  wr_en;
  logic                  yumi;
  logic                  token_due;

  assign empty = (wptr_r == rptr_r);
  // Same slot, opposite wrap bit
  assign full  = (wptr_r[LG_FIFO_DEPTH] != rptr_r[LG_FIFO_DEPTH])
              && (wptr_r[LG_FIFO_DEPTH-1:0] == rptr_r[LG_FIFO_DEPTH-1:0]);

  assign wr_en = link_v_i & ~reset_i;

  assign core_v_o    = ~empty & ~reset_i;
  assign core_data_o = mem_r[rptr_r[LG_FIFO_DEPTH-1:0]];
  assign yumi        = core_v_o & core_ready_i;

  // Last dequeue of a token's worth
  assign token_due = yumi && (deq_cnt_r == LG_DECIM'(CREDITS_PER_TOKEN - 1));

  always_ff @(posedge core_clk_i) begin
    if (wr_en) begin
      mem_r[wptr_r[LG_FIFO_DEPTH-1:0]] <= link_data_i;
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
    end else if (reset_i) begin
      wptr_r <= '0; // Flush
      rptr_r <= '0;
    end else begin
      if (wr_en) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (yumi) begin
        rptr_r <= rptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end else if (reset_i) begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end else begin
      if (yumi) begin
        deq_cnt_r <= deq_cnt_r + 1'b1; // Wraps at CREDITS_PER_TOKEN
      end
      token_r <= token_due;
    end
  end

  assign link_token_o = token_r;

  // Sender's credit accounting keeps this FIFO from overflowing
  a_no_write_full : assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    wr_en |-> !full
  );

endmodule

// File: sdr_link/sdr_link_up.sv
`timescale 1ns/1ps

module sdr_link_up
  import mc_link_pkg::*;
  #(parameter int width_p = 32)
  (input  logic               core_clk_i
  ,input  logic               arst_n_i
  ,input  logic               reset_i

  ,input  logic               core_v_i
  ,input  logic [width_p-1:0] core_data_i
  ,output logic               core_ready_o

  ,output logic               link_v_o
  ,output logic [width_p-1:0] link_data_o
  ,input  logic               link_token_i
  );

  logic [CREDIT_W-1:0] credit_r;
  logic [CREDIT_W-1:0] credit_add;
  logic                init_r;
  logic                link_v_r;
  logic [width_p-1:0]  link_data_r;
  logic                send;

  assign core_ready_o = (credit_r != '0) & ~reset_i;
  assign send         = core_v_i & core_ready_o;
  assign credit_add   = link_token_i ? CREDIT_W'(CREDITS_PER_TOKEN) : '0;

  // Credit count mirrors free slots in the far FIFO
  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      init_r   <= 1'b1;
      credit_r <= '0; // Keeps ready low through reset
    end else begin
      init_r <= 1'b0;
      if (init_r | reset_i) begin
        credit_r <= CREDIT_W'(FIFO_DEPTH);
      end else begin
        credit_r <= credit_r - CREDIT_W'(send) + credit_add;
      end
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      link_v_r <= 1'b0;
    end else begin
      link_v_r <= send;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (send) begin
      link_data_r <= core_data_i; // One word in flight
    end
  end

  assign link_v_o    = link_v_r;
  assign link_data_o = link_data_r;

  // Tokens coming back must never add up to more than the far FIFO holds
  a_credit_max : assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    credit_r <= CREDIT_W'(FIFO_DEPTH)
  );

endmodule

// File: testbench/tb_mc_link_to_sdr_north.sv
`timescale 1ns/1ps

module tb_mc_link_to_sdr_north
  import mc_link_pkg::*;
  ();

  localparam int NUM_PKTS   = 200;
  localparam int DIS_PKTS   = 40;
  localparam int EXTRA      = 4; // Words offered beyond the credit limit
  localparam int TOTAL_PKTS = 2 * NUM_PKTS + 2 * (FIFO_DEPTH + EXTRA) + DIS_PKTS;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_PKTS + 2000;

  logic                core_clk_i = 1'b1;
  logic                arst_n_i;
  logic                core_reset_i;
  logic [1:0]          core_reset_o;
  logic [X_CORD_W-1:0] core_global_x_i, core_global_x_o;
  logic [Y_CORD_W-1:0] core_global_y_i, core_global_y_o;
  logic async_uplink_reset_i, async_downlink_reset_i, async_downstream_reset_i;
  logic async_uplink_reset_o, async_downlink_reset_o, async_downstream_reset_o;
  logic async_token_reset_i, async_token_reset_o;
  logic async_fwd_link_i_disable_i, async_fwd_link_o_disable_i;
  logic async_rev_link_i_disable_i, async_rev_link_o_disable_i;
  logic core_fwd_v_i, core_fwd_ready_o, core_fwd_v_o, core_fwd_ready_i;
  logic [FWD_W-1:0] core_fwd_data_i, core_fwd_data_o;
  logic core_rev_v_i, core_rev_ready_o, core_rev_v_o, core_rev_ready_i;
  logic [REV_W-1:0] core_rev_data_i, core_rev_data_o;
  logic io_fwd_link_v_o, io_fwd_link_v_i, io_fwd_link_token_o, io_fwd_link_token_i;
  logic [FWD_W-1:0] io_fwd_link_data_o, io_fwd_link_data_i;
  logic io_rev_link_v_o, io_rev_link_v_i, io_rev_link_token_o, io_rev_link_token_i;
  logic [REV_W-1:0] io_rev_link_data_o, io_rev_link_data_i;

  // Index 0 is fwd, 1 is rev
  int   to_send [2];
  int   sent [2];
  int   deq [2];
  int   tokens [2];
  int   rdy_mode [2]; // 0 stall, 1 always, 2 random
  logic tok_en [2];
  logic fwd_tok_gate, rev_tok_gate;
  logic hk_rand, run_live, rev_hold;
  logic [FWD_W-1:0] fwd_q [$];
  logic [REV_W-1:0] rev_q [$];
  logic exp_reset;
  logic [X_CORD_W-1:0] exp_x;
  logic [Y_CORD_W-1:0] exp_y;

  always #4 core_clk_i = ~core_clk_i;

  // Link side folded back onto itself
  assign io_fwd_link_v_i     = io_fwd_link_v_o;
  assign io_fwd_link_data_i  = io_fwd_link_data_o;
  assign io_fwd_link_token_i = io_fwd_link_token_o & fwd_tok_gate;
  assign io_rev_link_v_i     = io_rev_link_v_o;
  assign io_rev_link_data_i  = io_rev_link_data_o;
  assign io_rev_link_token_i = io_rev_link_token_o & rev_tok_gate;

  mc_link_to_sdr_north u_mc_link_to_sdr_north (.*);

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic flag_mismatch(input string name, input logic [FWD_W-1:0] exp,
                               input logic [FWD_W-1:0] act);
    stop_with_failure($sformatf("mismatch at %0d ns: %s expected 0x%0h, actual 0x%0h",
                                $time, name, exp, act));
  endtask

  function automatic logic pick_ready(input int mode);
    if (mode == 2) begin
      return ($urandom % 3) != 0;
    end
    return mode == 1;
  endfunction

  function automatic logic ready_of(input int ch);
    return (ch == 0) ? core_fwd_ready_o : core_rev_ready_o;
  endfunction

  task automatic next_cycle();
    @(posedge core_clk_i);
    #1;
  endtask

  task automatic wait_drained(input int ch);
    while (to_send[ch] != 0 || (ch == 0 ? fwd_q.size() : rev_q.size()) != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle(); // Last token still on its way home
  endtask

  // Tokens held back, receiver stalled, so only the initial credit gets through
  task automatic check_credit_limit(input int ch);
    int start;
    start        = sent[ch];
    tok_en[ch]   = 1'b0;
    rdy_mode[ch] = 0;
    to_send[ch]  = FIFO_DEPTH + EXTRA;
    repeat (40) next_cycle();
    for (int i = 0; i < 10; i++) begin
      assert (!ready_of(ch)) else stop_with_failure("core ready high with no credit left");
      next_cycle();
    end
    assert (sent[ch] - start == FIFO_DEPTH)
      else flag_mismatch(ch == 0 ? "core_fwd_ready_o handshakes" : "core_rev_ready_o handshakes",
                         FWD_W'(FIFO_DEPTH), FWD_W'(sent[ch] - start));
    tok_en[ch]   = 1'b1;
    rdy_mode[ch] = 1;
    wait_drained(ch);
  endtask

  always @(negedge core_clk_i) begin
    core_fwd_v_i     = (to_send[0] > 0) && (($urandom % 4) != 0);
    core_fwd_data_i  = {$urandom, $urandom};
    core_fwd_ready_i = pick_ready(rdy_mode[0]);
    core_rev_v_i     = (to_send[1] > 0) && (($urandom % 4) != 0);
    core_rev_data_i  = REV_W'({$urandom, $urandom});
    core_rev_ready_i = pick_ready(rdy_mode[1]);
    fwd_tok_gate     = tok_en[0];
    rev_tok_gate     = tok_en[1];
    async_rev_link_o_disable_i = rev_hold;
    if (run_live) begin
      core_reset_i    = ($urandom % 2) != 0;
      core_global_x_i = X_CORD_W'($urandom);
      core_global_y_i = Y_CORD_W'($urandom);
    end
    {async_uplink_reset_i, async_downlink_reset_i, async_downstream_reset_i,
     async_token_reset_i} = hk_rand ? 4'($urandom) : 4'b0;
  end

  // Scoreboards and counters
  always @(posedge core_clk_i) begin
    if (arst_n_i) begin
      if (core_fwd_v_i && core_fwd_ready_o) begin
        fwd_q.push_back(core_fwd_data_i);
        to_send[0]--;
        sent[0]++;
      end
      if (core_rev_v_i && core_rev_ready_o) begin
        rev_q.push_back(core_rev_data_i);
        to_send[1]--;
        sent[1]++;
      end
      if (core_fwd_v_o && core_fwd_ready_i) begin
        assert (fwd_q.size() != 0) else stop_with_failure("fwd word out that was never sent");
        assert (core_fwd_data_o == fwd_q[0])
          else flag_mismatch("core_fwd_data_o", fwd_q[0], core_fwd_data_o);
        void'(fwd_q.pop_front());
        deq[0]++;
      end
      if (core_rev_v_o && core_rev_ready_i) begin
        assert (rev_q.size() != 0) else stop_with_failure("rev word out that was never sent");
        assert (core_rev_data_o == rev_q[0])
          else flag_mismatch("core_rev_data_o", FWD_W'(rev_q[0]), FWD_W'(core_rev_data_o));
        void'(rev_q.pop_front());
        deq[1]++;
      end
      tokens[0] += int'(io_fwd_link_token_o);
      tokens[1] += int'(io_rev_link_token_o);
    end
  end

  always @(posedge core_clk_i) begin
    if (arst_n_i) begin
      assert (core_reset_o == {2{exp_reset}})
        else flag_mismatch("core_reset_o", FWD_W'({2{exp_reset}}), FWD_W'(core_reset_o));
      assert (core_global_x_o == exp_x)
        else flag_mismatch("core_global_x_o", FWD_W'(exp_x), FWD_W'(core_global_x_o));
      assert (core_global_y_o == exp_y)
        else flag_mismatch("core_global_y_o", FWD_W'(exp_y), FWD_W'(core_global_y_o));
      assert ({async_uplink_reset_o, async_downlink_reset_o, async_downstream_reset_o,
               async_token_reset_o} == {async_uplink_reset_i, async_downlink_reset_i,
                                        async_downstream_reset_i, async_token_reset_i})
        else stop_with_failure("async reset outputs differ from their inputs");
    end
    exp_reset = core_reset_i;
    exp_x     = core_global_x_i;
    exp_y     = core_global_y_i;
  end

  a_rev_disabled : assert property (
    @(posedge core_clk_i) disable iff (!arst_n_i)
    async_rev_link_o_disable_i |-> !core_rev_ready_o && !io_rev_link_v_o
  ) else stop_with_failure("rev sender active while its link output is disabled");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge core_clk_i);
    stop_with_failure("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(10568));
    arst_n_i        = 1'b1;
    core_reset_i    = 1'b1;
    core_global_x_i = '0;
    core_global_y_i = '0;
    {async_uplink_reset_i, async_downlink_reset_i} = 2'b0;
    {async_downstream_reset_i, async_token_reset_i} = 2'b0;
    {async_fwd_link_i_disable_i, async_fwd_link_o_disable_i} = 2'b0;
    {async_rev_link_i_disable_i, async_rev_link_o_disable_i} = 2'b0;
    {core_fwd_v_i, core_rev_v_i, core_fwd_ready_i, core_rev_ready_i} = 4'b0011;
    core_fwd_data_i = '0;
    core_rev_data_i = '0;
    {fwd_tok_gate, rev_tok_gate} = 2'b11;
    for (int ch = 0; ch < 2; ch++) begin
      to_send[ch]  = 0;
      sent[ch]     = 0;
      deq[ch]      = 0;
      tokens[ch]   = 0;
      rdy_mode[ch] = 1;
      tok_en[ch]   = 1'b1;
    end
    {hk_rand, run_live, rev_hold} = 3'b0;
    exp_reset = 1'b1;
    exp_x     = '0;
    exp_y     = '0;

    @(negedge core_clk_i);
    arst_n_i = 1'b0;
    repeat (5) @(negedge core_clk_i);
    assert ({core_fwd_v_o, core_rev_v_o, io_fwd_link_v_o, io_rev_link_v_o,
             io_fwd_link_token_o, io_rev_link_token_o,
             core_fwd_ready_o, core_rev_ready_o} == 8'b0)
      else stop_with_failure("valid, token or ready output high during reset");
    arst_n_i = 1'b1;
    next_cycle();
    assert (core_fwd_ready_o && core_rev_ready_o)
      else stop_with_failure("core ready did not rise after reset release");
    run_live = 1'b1;

    hk_rand = 1'b1;
    repeat (30) next_cycle();
    hk_rand = 1'b0;
    repeat (8) next_cycle(); // Synchronizers clear, credits reload

    rdy_mode[0] = 2;
    rdy_mode[1] = 2;
    to_send[0]  = NUM_PKTS;
    to_send[1]  = NUM_PKTS;
    wait_drained(0);
    wait_drained(1);

    check_credit_limit(0);

    rev_hold    = 1'b1;
    to_send[1]  = EXTRA; // Offered, never taken
    rdy_mode[0] = 2;
    to_send[0]  = DIS_PKTS;
    wait_drained(0);
    assert (to_send[1] == EXTRA)
      else flag_mismatch("core_rev_ready_o handshakes", '0, FWD_W'(EXTRA - to_send[1]));
    to_send[1] = 0;
    rev_hold   = 1'b0;
    check_credit_limit(1);

    assert (tokens[0] == deq[0] / CREDITS_PER_TOKEN)
      else flag_mismatch("io_fwd_link_token_o pulses", FWD_W'(deq[0] / CREDITS_PER_TOKEN),
                         FWD_W'(tokens[0]));
    assert (tokens[1] == deq[1] / CREDITS_PER_TOKEN)
      else flag_mismatch("io_rev_link_token_o pulses", FWD_W'(deq[1] / CREDITS_PER_TOKEN),
                         FWD_W'(tokens[1]));

    $display("All tests passed");
    $finish;
  end

endmodule

// File: verilog.f
common/mc_link_pkg.sv
design/mc_tile_regs.sv
sdr_link/sdr_link_up.sv
sdr_link/sdr_link_down.sv
sdr_link/sdr_link.sv
design/mc_link_to_sdr_north.sv
testbench/tb_mc_link_to_sdr_north.sv
